// File: dv/mipsCoreTb.sv
`include "mipsCore_defines.svh"

module mipsCoreTb
    import mipsPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam string PATTERN_FILE = "dv/mipsPatterns.txt";
    localparam int    MEM_WORDS    = 256;

    logic  clk;
    logic  rst;
    word_t instrAddr;
    word_t instr;
    word_t dataAddr;
    word_t dataWrite;
    logic  dataWriteEn;
    word_t dataRead;

    word_t instrMem [0:MEM_WORDS-1];
    word_t dataMem  [0:MEM_WORDS-1];

    word_t storeAddrs [$]; // Expected store events, in order
    word_t storeData  [$];
    word_t flowTargets [$]; // PC after each taken branch or jump

    int    instrCount;
    int    cycles;
    int    cycleLimit;
    int    storeIdx;
    int    flowIdx;
    word_t prevAddr;
    logic  havePrev;
    word_t firstWord; // Program word at RESET_PC

    mipsCore dut_i (
        .clk         (clk),
        .rst         (rst),
        .instrAddr   (instrAddr),
        .instr       (instr),
        .dataAddr    (dataAddr),
        .dataWrite   (dataWrite),
        .dataWriteEn (dataWriteEn),
        .dataRead    (dataRead)
    );

    // Both memories read combinationally by word address
    assign instr    = instrMem[instrAddr[9:2]];
    assign dataRead = dataMem[dataAddr[9:2]];

    always @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
                dataMem[i] <= 32'hA500_0000 | (word_t'(i) << 2); // Byte address in low bits
        end
        else if (dataWriteEn)
        begin
            dataMem[dataAddr[9:2]] <= dataWrite;
        end
    end

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "run stopped after the first failure");
    endtask

    task automatic checkWord(input string testName, input word_t expected, input word_t actual);
        if (expected !== actual)
            failRun($sformatf("ERR %s: expected %h, actual %h", testName, expected, actual));
    endtask

    task automatic checkFlag(input string testName, input logic expected, input logic actual);
        if (expected !== actual)
            failRun($sformatf("ERR %s: expected %b, actual %b", testName, expected, actual));
    endtask

    task automatic loadPatterns();
        int         fd;
        int         c;
        int         n;
        logic [7:0] tag;
        word_t      first;
        word_t      second;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0)
            failRun("Could not open the patterns file dv/mipsPatterns.txt");
        c = $fgetc(fd);
        while (c != -1)
        begin
            tag = 8'(c);
            if (tag == "#")
            begin
                // Comment runs to end of line
                while (c != -1 && c != 10)
                    c = $fgetc(fd);
            end
            else if (tag == "I" || tag == "P")
            begin
                n = $fscanf(fd, " %h", first);
                if (n != 1)
                    failRun("A line of the patterns file has a missing or bad value");
                else if (tag == "P")
                    flowTargets.push_back(first);
                else if (instrCount >= MEM_WORDS)
                    failRun("The program in the patterns file is larger than the memory");
                else
                begin
                    instrMem[instrCount] = first;
                    instrCount++;
                end
            end
            else if (tag == "S")
            begin
                n = $fscanf(fd, " %h %h", first, second);
                if (n != 2)
                    failRun("A store line of the patterns file needs an address and a data word");
                storeAddrs.push_back(first);
                storeData.push_back(second);
            end
            else if (tag != " " && tag != "\t" && tag != "\n" && tag != "\r")
            begin
                failRun($sformatf("Unknown line type '%c' in the patterns file", tag));
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        if (instrCount == 0 || storeAddrs.size() == 0)
            failRun("The patterns file holds no program or no expected stores");
    endtask

    // One sample per executed instruction, mid-cycle
    task automatic observeCycle();
        cycles++;
        if (cycles > cycleLimit)
            failRun("Timeout, the expected stores and jumps never arrived");
        if (havePrev && instrAddr != prevAddr + 32'd4)
        begin
            if (flowIdx >= flowTargets.size())
                failRun($sformatf("Unexpected jump from %h to %h", prevAddr, instrAddr));
            checkWord($sformatf("flow event %0d pc", flowIdx), flowTargets[flowIdx], instrAddr);
            flowIdx++;
        end
        prevAddr = instrAddr;
        havePrev = 1'b1;
        if (dataWriteEn)
        begin
            if (storeIdx >= storeAddrs.size())
                failRun($sformatf("Unexpected store to %h at pc %h", dataAddr, instrAddr));
            checkWord($sformatf("store %0d address", storeIdx), storeAddrs[storeIdx], dataAddr);
            checkWord($sformatf("store %0d data", storeIdx), storeData[storeIdx], dataWrite);
            storeIdx++;
        end
    endtask

    initial
    begin
        rst        = 1'b1;
        instrCount = 0;
        cycles     = 0;
        storeIdx   = 0;
        flowIdx    = 0;
        prevAddr   = '0;
        havePrev   = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
            instrMem[i] = 32'hFC00_0000 | word_t'(i); // Undefined opcode with the index
        loadPatterns();
        cycleLimit = 4 * instrCount + 64;

        // A store sits at the reset address while rst is high
        firstWord   = instrMem[0];
        instrMem[0] = {`OPCODE_SW, 5'd0, 5'd0, 16'h0000};
        repeat (2)
        begin
            @(negedge clk);
            checkFlag("reset store enable", 1'b0, dataWriteEn);
        end
        instrMem[0] = firstWord;
        rst = 1'b0;
        #1;
        checkWord("start address", `RESET_PC, instrAddr);

        while (storeIdx < storeAddrs.size() || flowIdx < flowTargets.size())
        begin
            observeCycle();
            @(negedge clk);
            #1;
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// File: dv/mipsPatterns.txt
# I <word> program word in address order from 0, S <addr> <data> expected store in order
# P <pc> expected pc right after each taken branch or jump, text after # is ignored
I 20010005  # 00 addi r1, r0, 5
I 2002FFFD  # 04 addi r2, r0, -3
I 34038000  # 08 ori  r3, r0, 0x8000
I 00222020  # 0c add  r4, r1, r2
I AC040000  # 10 sw   r4, 0(r0)
I 00422821  # 14 addu r5, r2, r2
I AC050004  # 18 sw   r5, 4(r0)
I 00223022  # 1c sub  r6, r1, r2
I AC060008  # 20 sw   r6, 8(r0)
I 00413823  # 24 subu r7, r2, r1
I AC07000C  # 28 sw   r7, 12(r0)
I 00434024  # 2c and  r8, r2, r3
I AC080010  # 30 sw   r8, 16(r0)
I 00234825  # 34 or   r9, r1, r3
I AC090014  # 38 sw   r9, 20(r0)
I 0041502A  # 3c slt  r10, r2, r1
I AC0A0018  # 40 sw   r10, 24(r0)
I 0041582B  # 44 sltu r11, r2, r1
I AC0B001C  # 48 sw   r11, 28(r0)
I AC030020  # 4c sw   r3, 32(r0)
I 8C0C0000  # 50 lw   r12, 0(r0)
I 218C0064  # 54 addi r12, r12, 100
I AC0C0024  # 58 sw   r12, 36(r0)
I 20000007  # 5c addi r0, r0, 7
I AC000028  # 60 sw   r0, 40(r0)
I FC211234  # 64 undefined opcode
I 0021083F  # 68 undefined funct, rd r1
I AC01002C  # 6c sw   r1, 44(r0)
I 10220001  # 70 beq  r1, r2, +1 not taken
I AC010030  # 74 sw   r1, 48(r0)
I 10840001  # 78 beq  r4, r4, +1 taken
I AC020034  # 7c sw   r2, 52(r0) skipped
I AC060034  # 80 sw   r6, 52(r0)
I 08000023  # 84 j    0x8c
I AC070038  # 88 sw   r7, 56(r0) skipped
I AC090038  # 8c sw   r9, 56(r0)
I 08000024  # 90 j    0x90 end of program
S 00000000 00000002
S 00000004 FFFFFFFA
S 00000008 00000008
S 0000000C FFFFFFF8
S 00000010 00008000
S 00000014 00008005
S 00000018 00000001
S 0000001C 00000000
S 00000020 00008000
S 00000024 00000066
S 00000028 00000000
S 0000002C 00000005
S 00000030 00000005
S 00000034 00000008
S 00000038 00008005
P 00000080
P 0000008C
P 00000090

// File: project.f
+incdir+source
source/mipsPkg.sv
source/ctrlBus.sv
source/control.sv
source/alu.sv
source/regFile.sv
source/pcUnit.sv
source/mipsCore.sv
dv/mipsCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module mipsCoreTb -f project.f -o simMipsCore
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simMipsCore > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" sim.log; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1

// File: source/alu.sv
module alu
    import mipsPkg::*;
(
    input  word_t  a,
    input  word_t  b,
    input  aluOp_t aluOp,
    output word_t  result,
    output logic   zero
);

    word_t sum;
    word_t diff;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb
    begin
        case (aluOp)
            ALU_ADD:  result = sum;
            ALU_SUB:  result = diff;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_SLT:
            begin
                // Two's complement compare
                result = word_t'($signed(a) < $signed(b));
            end
            ALU_SLTU: result = word_t'(a < b);
            default:  result = '0; // NOP and unused codes
        endcase
    end

    // Used by BEQ
    assign zero = (result == '0);

endmodule

// File: source/control.sv
`include "mipsCore_defines.svh"

module control
    import mipsPkg::*;
(
    input word_t    instr,
    ctrlBus.decoder ctrl
);

    opcode_t opcode;
    funct_t  funct;
    aluOp_t  rTypeOp;    // ALU op picked by funct
    logic    rTypeValid; // Funct is one we support

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    // R-type funct decode, unsigned forms share the signed ALU ops
    always_comb
    begin
        rTypeValid = 1'b1;
        case (funct)
            `FUNCT_ADD, `FUNCT_ADDU: rTypeOp = ALU_ADD; // No overflow trap
            `FUNCT_SUB, `FUNCT_SUBU: rTypeOp = ALU_SUB;
            `FUNCT_AND:              rTypeOp = ALU_AND;
            `FUNCT_OR:               rTypeOp = ALU_OR;
            `FUNCT_SLT:              rTypeOp = ALU_SLT;
            `FUNCT_SLTU:             rTypeOp = ALU_SLTU;
            default:
            begin
                rTypeOp    = ALU_NOP;
                rTypeValid = 1'b0;
            end
        endcase
    end

    always_comb
    begin
        // Defaults act as a no-op, also for unknown opcodes
        ctrl.regDst   = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.aluOp    = ALU_NOP;
        ctrl.memWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.extZero  = 1'b0;

        case (opcode)
            `OPCODE_R:
            begin
                ctrl.regDst   = 1'b1;
                ctrl.aluOp    = rTypeOp;
                ctrl.regWrite = rTypeValid; // Bad funct writes nothing
            end
            `OPCODE_ADDI:
            begin
                ctrl.aluOp    = ALU_ADD;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `OPCODE_ORI:
            begin
                ctrl.aluOp    = ALU_OR;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.extZero  = 1'b1;
            end
            `OPCODE_LW:
            begin
                ctrl.memToReg = 1'b1;
                ctrl.aluOp    = ALU_ADD; // Base plus offset
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `OPCODE_SW:
            begin
                ctrl.aluOp    = ALU_ADD;
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            `OPCODE_BEQ:
            begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = ALU_SUB; // Equal when difference is zero
            end
            `OPCODE_J: ctrl.jump = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: source/ctrlBus.sv
interface ctrlBus
    import mipsPkg::*;
();

    logic   regDst;   // Write to rd instead of rt
    logic   jump;
    logic   branch;
    logic   memToReg; // Write-back from memory
    aluOp_t aluOp;
    logic   memWrite;
    logic   aluSrc;   // Second operand from immediate
    logic   regWrite;
    logic   extZero;  // Zero-extend immediate (ORI)

    modport decoder (
        output regDst, jump, branch, memToReg, aluOp,
        output memWrite, aluSrc, regWrite, extZero
    );

    modport flow (input jump, branch);

    modport datapath (
        input regDst, memToReg, aluSrc, regWrite, memWrite, extZero, aluOp
    );

endinterface

// File: source/mipsCore.sv
module mipsCore
    import mipsPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    output word_t instrAddr,
    input  word_t instr,
    output word_t dataAddr,
    output word_t dataWrite,
    output logic  dataWriteEn,
    input  word_t dataRead
);

    ctrlBus ctrl ();

    regIdx_t    rs;
    regIdx_t    rt;
    regIdx_t    rd;
    regIdx_t    writeReg;
    logic [15:0] imm;
    word_t      immExt;
    word_t      regA;
    word_t      regB;
    word_t      aluB;
    word_t      aluResult;
    logic       aluZero;
    word_t      writeBack;
    word_t      pc;
    logic       regWriteEn;

    assign rs  = instr[25:21];
    assign rt  = instr[20:16];
    assign rd  = instr[15:11];
    assign imm = instr[15:0];

    // Sign extension except for ORI
    assign immExt = ctrl.extZero ? {16'b0, imm} : {{16{imm[15]}}, imm};
    assign aluB   = ctrl.aluSrc ? immExt : regB;

    assign writeReg   = ctrl.regDst ? rd : rt;
    assign writeBack  = ctrl.memToReg ? dataRead : aluResult;
    assign regWriteEn = ctrl.regWrite && !rst; // Quiet during reset

    control decoder_i (
        .instr (instr),
        .ctrl  (ctrl)
    );

    regFile regs_i (
        .clk       (clk),
        .rst       (rst),
        .readAddrA (rs),
        .readAddrB (rt),
        .readDataA (regA),
        .readDataB (regB),
        .writeEn   (regWriteEn),
        .writeAddr (writeReg),
        .writeData (writeBack)
    );

    alu alu_i (
        .a      (regA),
        .b      (aluB),
        .aluOp  (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    pcUnit pcUnit_i (
        .clk   (clk),
        .rst   (rst),
        .ctrl  (ctrl),
        .zero  (aluZero),
        .instr (instr),
        .pc    (pc)
    );

    // Memory side
    assign instrAddr   = pc;
    assign dataAddr    = aluResult;
    assign dataWrite   = regB;
    assign dataWriteEn = ctrl.memWrite && !rst;

endmodule

// File: source/mipsCore_defines.svh
`ifndef MIPSCORE_DEFINES_SVH
`define MIPSCORE_DEFINES_SVH

// Primary opcode field, instr[31:26]
`define OPCODE_R     6'b000000
`define OPCODE_ADDI  6'b001000
`define OPCODE_ORI   6'b001101
`define OPCODE_LW    6'b100011
`define OPCODE_SW    6'b101011
`define OPCODE_BEQ   6'b000100
`define OPCODE_J     6'b000010

// Function field of R-type, instr[5:0]
`define FUNCT_ADD    6'b100000
`define FUNCT_ADDU   6'b100001
`define FUNCT_SUB    6'b100010
`define FUNCT_SUBU   6'b100011
`define FUNCT_AND    6'b100100
`define FUNCT_OR     6'b100101
`define FUNCT_SLT    6'b101010
`define FUNCT_SLTU   6'b101011

`define DATA_WIDTH   32
`define REG_COUNT    32

// First fetch address after reset
`define RESET_PC     32'h0000_0000

`endif

// File: source/mipsPkg.sv
`include "mipsCore_defines.svh"

package mipsPkg;

    // Data and address word
    typedef logic [`DATA_WIDTH-1:0] word_t;

    // Register number, 5 bits for 32 registers
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;

    typedef logic [5:0] opcode_t; // instr[31:26]
    typedef logic [5:0] funct_t;  // instr[5:0]

    // ALU operation select
    typedef enum logic [2:0] {
        ALU_NOP  = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_SLT  = 3'd5,
        ALU_SLTU = 3'd6
    } aluOp_t;

endpackage

// File: source/pcUnit.sv
`include "mipsCore_defines.svh"

module pcUnit
    import mipsPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    ctrlBus.flow  ctrl,
    input  logic  zero,
    input  word_t instr,
    output word_t pc
);

    word_t pcPlus4;
    word_t branchOffset;
    word_t branchTarget;
    word_t jumpTarget;
    word_t nextPc;

    assign pcPlus4 = pc + 32'd4;

    // Sign-extended word offset
    assign branchOffset = {{14{instr[15]}}, instr[15:0], 2'b00};
    assign branchTarget = pcPlus4 + branchOffset;

    // Region of pc + 4 with the 26-bit word index
    assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

    always_comb
    begin
        nextPc = pcPlus4; // Sequential flow
        if (ctrl.jump)
            nextPc = jumpTarget;
        else if (ctrl.branch && zero)
            nextPc = branchTarget; // Taken BEQ
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= `RESET_PC;
        else
            pc <= nextPc;
    end

endmodule

// File: source/regFile.sv
`include "mipsCore_defines.svh"

module regFile
    import mipsPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  regIdx_t readAddrA,
    input  regIdx_t readAddrB,
    output word_t   readDataA,
    output word_t   readDataB,
    input  logic    writeEn,
    input  regIdx_t writeAddr,
    input  word_t   writeData
);

    // Register 0 has no storage
    word_t regs [1:`REG_COUNT-1];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 1; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (writeEn && (writeAddr != '0))
        begin
            regs[writeAddr] <= writeData;
        end
    end

    // Combinational read, old value during a same-cycle write
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule
